//--- Makefile
# Verilator build and run for the RV32I ALU core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_alu_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module alu_execute import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      dec_vld_i,
    input  logic      dec_illegal_i,
    input  logic      dec_wen_i,
    input  reg_addr_t dec_rd_i,
    input  reg_addr_t dec_rs1_i,
    input  reg_addr_t dec_rs2_i,
    input  word_t     dec_rs1_data_i,
    input  word_t     dec_rs2_data_i,
    input  word_t     dec_imm_i,
    input  logic      dec_use_imm_i,
    input  alu_op_e   dec_alu_op_i,
    input  logic      fwd_wen_i,
    input  reg_addr_t fwd_rd_i,
    input  word_t     fwd_data_i,
    output logic      ex_vld_o,
    output logic      ex_illegal_o,
    output logic      ex_wen_o,
    output reg_addr_t ex_rd_o,
    output word_t     ex_result_o
);

    localparam int unsigned SHAMT_W = $clog2(`CORE_XLEN);

    logic               vld_q;
    logic               illegal_q;
    logic               wen_q;
    reg_addr_t          rd_q;
    reg_addr_t          rs1_q;
    reg_addr_t          rs2_q;
    word_t              rs1_data_q;
    word_t              rs2_data_q;
    word_t              imm_q;
    logic               use_imm_q;
    alu_op_e            alu_op_q;
    word_t              op_a;
    word_t              rs2_val;
    word_t              op_b;
    logic [SHAMT_W-1:0] shamt;
    word_t              result;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vld_q     <= 1'b0;
            illegal_q <= 1'b0;
            wen_q     <= 1'b0;
        end else begin
            vld_q     <= dec_vld_i;
            illegal_q <= dec_illegal_i;
            wen_q     <= dec_wen_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_vld_i) begin
            rd_q       <= dec_rd_i;
            rs1_q      <= dec_rs1_i;
            rs2_q      <= dec_rs2_i;
            rs1_data_q <= dec_rs1_data_i;
            rs2_data_q <= dec_rs2_data_i;
            imm_q      <= dec_imm_i;
            use_imm_q  <= dec_use_imm_i;
            alu_op_q   <= dec_alu_op_i;
        end
    end

    // Result stage holds the previous instruction, its value is newer than the read
    assign op_a    = (fwd_wen_i && (fwd_rd_i == rs1_q)) ? fwd_data_i : rs1_data_q;
    assign rs2_val = (fwd_wen_i && (fwd_rd_i == rs2_q)) ? fwd_data_i : rs2_data_q;
    assign op_b    = use_imm_q ? imm_q : rs2_val;
    assign shamt   = op_b[SHAMT_W-1:0];

    always_comb begin
        case (alu_op_q)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SLT:    result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   result = word_t'(op_a < op_b);
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = word_t'($signed(op_a) >>> shamt);
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    assign ex_vld_o     = vld_q;
    assign ex_illegal_o = illegal_q;
    assign ex_wen_o     = wen_q;
    assign ex_rd_o      = rd_q;
    assign ex_result_o  = result;

endmodule

`default_nettype wire

//--- core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Width of a data word and of an instruction word
`define CORE_XLEN 32

// Architectural integer registers, x0 included
`define CORE_NREGS 32

// Bits needed to index one register
`define CORE_REG_AW 5

`endif

//--- core_pkg.sv
`default_nettype none

`include "core_defines.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;

    typedef logic [`CORE_REG_AW-1:0] reg_addr_t;

    // ALU functions, PASS_B forwards operand B untouched for LUI
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

endpackage

`default_nettype wire

//--- insn_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module insn_decode import isa_pkg::*, core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      insn_vld_i,
    input  insn_t     insn_i,
    input  word_t     rf_rs1_data_i,
    input  word_t     rf_rs2_data_i,
    output reg_addr_t rf_rs1_addr_o,
    output reg_addr_t rf_rs2_addr_o,
    output logic      dec_vld_o,
    output logic      dec_illegal_o,
    output logic      dec_wen_o,
    output reg_addr_t dec_rd_o,
    output reg_addr_t dec_rs1_o,
    output reg_addr_t dec_rs2_o,
    output word_t     dec_rs1_data_o,
    output word_t     dec_rs2_data_o,
    output word_t     dec_imm_o,
    output logic      dec_use_imm_o,
    output alu_op_e   dec_alu_op_o
);

    logic    vld_q;
    insn_t   insn_q;
    opcode_e opcode;
    funct3_e funct3;
    funct7_t funct7;
    word_t   imm_i_type;
    word_t   imm_u_type;
    logic    legal;
    logic    use_imm;
    word_t   imm;
    alu_op_e alu_op;

    // Maps funct3 to an ALU function with alt picking SUB or SRA
    function automatic alu_op_e base_op(funct3_e f3, logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= insn_vld_i;
        end
    end

    // Instruction word only loads on a strobe
    always_ff @(posedge clk_i) begin
        if (insn_vld_i) begin
            insn_q <= insn_i;
        end
    end

    assign opcode = opcode_e'(insn_q[6:0]);
    assign funct3 = funct3_e'(insn_q[14:12]);
    assign funct7 = insn_q[31:25];

    assign imm_i_type = {{(`CORE_XLEN-12){insn_q[31]}}, insn_q[31:20]};
    assign imm_u_type = {insn_q[31:12], 12'h000};

    always_comb begin
        legal   = 1'b0;
        use_imm = 1'b0;
        imm     = imm_i_type;
        alu_op  = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                alu_op = base_op(funct3, funct7[5]);
                legal  = (funct7 == F7_BASE) ||
                         ((funct7 == F7_ALT) &&
                          (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                // ADDI has no SUB form since the top bits are immediate
                alu_op  = base_op(funct3, (funct3 == F3_SRL_SRA) && funct7[5]);
                case (funct3)
                    F3_SLL:     legal = (funct7 == F7_BASE);
                    F3_SRL_SRA: legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    default:    legal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                imm     = imm_u_type;
                alu_op  = ALU_PASS_B;
            end
            default: legal = 1'b0;
        endcase
    end

    assign rf_rs1_addr_o = insn_q[19:15];
    assign rf_rs2_addr_o = insn_q[24:20];

    assign dec_vld_o      = vld_q;
    assign dec_illegal_o  = vld_q & ~legal;
    // Only place where x0 is filtered out
    assign dec_wen_o      = vld_q & legal & (insn_q[11:7] != '0);
    assign dec_rd_o       = insn_q[11:7];
    assign dec_rs1_o      = insn_q[19:15];
    assign dec_rs2_o      = insn_q[24:20];
    assign dec_rs1_data_o = rf_rs1_data_i;
    assign dec_rs2_data_o = rf_rs2_data_i;
    assign dec_imm_o      = imm;
    assign dec_use_imm_o  = use_imm;
    assign dec_alu_op_o   = alu_op;

endmodule

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

`include "core_defines.svh"

package isa_pkg;

    // RV32I instructions are one word wide
    typedef logic [`CORE_XLEN-1:0] insn_t;

    // Upper function field of R-type and shift-immediate encodings
    typedef logic [6:0] funct7_t;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // Integer operation selector, shared by OP and OP-IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    // funct7 patterns
    localparam funct7_t F7_BASE = 7'b0000000;
    // Selects SUB and the arithmetic right shift
    localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

//--- project.f
+incdir+.
isa_pkg.sv
core_pkg.sv
insn_decode.sv
regfile.sv
alu_execute.sv
result_stage.sv
rv_alu_core.sv
tb_rv_alu_core.sv

//--- regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module regfile import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      wen_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs_q [`CORE_NREGS];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wen_i) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // x0 reads zero, a same-cycle write wins over the stored value
    assign rdata1_o = (raddr1_i == '0)                  ? '0      :
                      (wen_i && (waddr_i == raddr1_i)) ? wdata_i :
                                                          regs_q[raddr1_i];

    assign rdata2_o = (raddr2_i == '0)                  ? '0      :
                      (wen_i && (waddr_i == raddr2_i)) ? wdata_i :
                                                          regs_q[raddr2_i];

    // Decode drops x0 writes before they reach the write port
    a_no_x0_write: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wen_i |-> (waddr_i != '0)
    );

endmodule

`default_nettype wire

//--- result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      ex_vld_i,
    input  logic      ex_illegal_i,
    input  logic      ex_wen_i,
    input  reg_addr_t ex_rd_i,
    input  word_t     ex_result_i,
    output logic      retire_vld_o,
    output logic      retire_illegal_o,
    output logic      retire_wen_o,
    output reg_addr_t retire_rd_o,
    output word_t     retire_data_o
);

    logic      vld_q;
    logic      illegal_q;
    logic      wen_q;
    reg_addr_t rd_q;
    word_t     data_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vld_q     <= 1'b0;
            illegal_q <= 1'b0;
            wen_q     <= 1'b0;
        end else begin
            vld_q     <= ex_vld_i;
            illegal_q <= ex_vld_i & ex_illegal_i;
            // Bubbles never write back
            wen_q     <= ex_vld_i & ex_wen_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rd_q   <= ex_rd_i;
        data_q <= ex_result_i;
    end

    assign retire_vld_o     = vld_q;
    assign retire_illegal_o = illegal_q;
    assign retire_wen_o     = wen_q;
    assign retire_rd_o      = rd_q;
    assign retire_data_o    = data_q;

    a_retire_no_x0: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        retire_wen_o |-> (retire_rd_o != '0)
    );

    a_illegal_no_write: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        retire_illegal_o |-> !retire_wen_o
    );

endmodule

`default_nettype wire

//--- rv_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu_core import isa_pkg::*, core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      insn_vld_i,
    input  insn_t     insn_i,
    output logic      retire_vld_o,
    output logic      retire_illegal_o,
    output logic      retire_wen_o,
    output reg_addr_t retire_rd_o,
    output word_t     retire_data_o
);

    // Register file read port
    reg_addr_t rf_rs1_addr;
    reg_addr_t rf_rs2_addr;
    word_t     rf_rs1_data;
    word_t     rf_rs2_data;

    // Decode to execute
    logic      dec_vld;
    logic      dec_illegal;
    logic      dec_wen;
    reg_addr_t dec_rd;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    word_t     dec_rs1_data;
    word_t     dec_rs2_data;
    word_t     dec_imm;
    logic      dec_use_imm;
    alu_op_e   dec_alu_op;

    // Execute to result
    logic      ex_vld;
    logic      ex_illegal;
    logic      ex_wen;
    reg_addr_t ex_rd;
    word_t     ex_result;

    insn_decode u_insn_decode (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .insn_vld_i     (insn_vld_i),
        .insn_i         (insn_i),
        .rf_rs1_data_i  (rf_rs1_data),
        .rf_rs2_data_i  (rf_rs2_data),
        .rf_rs1_addr_o  (rf_rs1_addr),
        .rf_rs2_addr_o  (rf_rs2_addr),
        .dec_vld_o      (dec_vld),
        .dec_illegal_o  (dec_illegal),
        .dec_wen_o      (dec_wen),
        .dec_rd_o       (dec_rd),
        .dec_rs1_o      (dec_rs1),
        .dec_rs2_o      (dec_rs2),
        .dec_rs1_data_o (dec_rs1_data),
        .dec_rs2_data_o (dec_rs2_data),
        .dec_imm_o      (dec_imm),
        .dec_use_imm_o  (dec_use_imm),
        .dec_alu_op_o   (dec_alu_op)
    );

    // Written from the retiring instruction
    regfile u_regfile (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .wen_i    (retire_wen_o),
        .waddr_i  (retire_rd_o),
        .wdata_i  (retire_data_o),
        .raddr1_i (rf_rs1_addr),
        .raddr2_i (rf_rs2_addr),
        .rdata1_o (rf_rs1_data),
        .rdata2_o (rf_rs2_data)
    );

    alu_execute u_alu_execute (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .dec_vld_i      (dec_vld),
        .dec_illegal_i  (dec_illegal),
        .dec_wen_i      (dec_wen),
        .dec_rd_i       (dec_rd),
        .dec_rs1_i      (dec_rs1),
        .dec_rs2_i      (dec_rs2),
        .dec_rs1_data_i (dec_rs1_data),
        .dec_rs2_data_i (dec_rs2_data),
        .dec_imm_i      (dec_imm),
        .dec_use_imm_i  (dec_use_imm),
        .dec_alu_op_i   (dec_alu_op),
        .fwd_wen_i      (retire_wen_o),
        .fwd_rd_i       (retire_rd_o),
        .fwd_data_i     (retire_data_o),
        .ex_vld_o       (ex_vld),
        .ex_illegal_o   (ex_illegal),
        .ex_wen_o       (ex_wen),
        .ex_rd_o        (ex_rd),
        .ex_result_o    (ex_result)
    );

    result_stage u_result_stage (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .ex_vld_i         (ex_vld),
        .ex_illegal_i     (ex_illegal),
        .ex_wen_i         (ex_wen),
        .ex_rd_i          (ex_rd),
        .ex_result_i      (ex_result),
        .retire_vld_o     (retire_vld_o),
        .retire_illegal_o (retire_illegal_o),
        .retire_wen_o     (retire_wen_o),
        .retire_rd_o      (retire_rd_o),
        .retire_data_o    (retire_data_o)
    );

endmodule

`default_nettype wire

//--- tb_rv_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_alu_core;

    localparam logic [31:0] SEED         = 32'h3d7e_afde;
    localparam int          RESET_CYCLES = 4;
    localparam int          RANDOM_COUNT = 400;
    localparam int          DRAIN_LIMIT  = 50;
    localparam int          LATENCY      = 3;

    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;

    // One expected retire record
    typedef struct packed {
        logic        illegal;
        logic        wen;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] issue_cyc;
    } exp_t;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        insn_vld_i;
    logic [31:0] insn_i;
    logic        retire_vld_o;
    logic        retire_illegal_o;
    logic        retire_wen_o;
    logic [4:0]  retire_rd_o;
    logic [31:0] retire_data_o;

    logic [31:0] model_regs [32];
    exp_t        exp_q [$];
    int unsigned neg_cnt = 0;
    int unsigned mismatch_cnt = 0;
    int unsigned failure_cnt = 0;

    rv_alu_core u_rv_alu_core (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .insn_vld_i       (insn_vld_i),
        .insn_i           (insn_i),
        .retire_vld_o     (retire_vld_o),
        .retire_illegal_o (retire_illegal_o),
        .retire_wen_o     (retire_wen_o),
        .retire_rd_o      (retire_rd_o),
        .retire_data_o    (retire_data_o)
    );

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OPC_REG};
    endfunction

    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), OPC_IMM};
    endfunction

    function automatic logic [31:0] enc_lui(int imm, int rd);
        return {20'(imm), 5'(rd), OPC_LUI};
    endfunction

    // RV32I integer result for one funct3 with alt selecting SUB or SRA
    function automatic logic [31:0] int_op(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Architectural model that executes in issue order and updates model_regs
    function automatic exp_t model_execute(logic [31:0] insn);
        exp_t        e;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] imm;
        logic        ok;
        f7     = insn[31:25];
        f3     = insn[14:12];
        a      = model_regs[insn[19:15]];
        imm    = {{20{insn[31]}}, insn[31:20]};
        ok     = 1'b0;
        e      = '0;
        e.rd   = insn[11:7];
        if (insn[6:0] == OPC_REG) begin
            ok     = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
            e.data = int_op(f3, f7 == 7'h20, a, model_regs[insn[24:20]]);
        end else if (insn[6:0] == OPC_IMM) begin
            if (f3 == 3'd1) begin
                ok = (f7 == 7'h00);
            end else if (f3 == 3'd5) begin
                ok = (f7 == 7'h00) || (f7 == 7'h20);
            end else begin
                ok = 1'b1;
            end
            e.data = int_op(f3, (f3 == 3'd5) && (f7 == 7'h20), a, imm);
        end else if (insn[6:0] == OPC_LUI) begin
            ok     = 1'b1;
            e.data = {insn[31:12], 12'h000};
        end
        e.illegal = !ok;
        e.wen     = ok && (e.rd != 5'd0);
        if (e.wen) begin
            model_regs[e.rd] = e.data;
        end
        return e;
    endfunction

    // Mix of legal ops on x0..x7 and several illegal forms
    function automatic logic [31:0] random_insn();
        int unsigned kind;
        int          rd;
        int          rs1;
        int          rs2;
        int          f3;
        int          imm;
        kind = $urandom % 16;
        rd   = $urandom % 8;
        rs1  = $urandom % 8;
        rs2  = $urandom % 8;
        f3   = $urandom % 8;
        imm  = $urandom % 4096;
        if (kind < 6) begin
            return enc_r(((f3 == 0 || f3 == 5) && ($urandom % 2 == 1)) ? 'h20 : 0,
                         rs2, rs1, f3, rd);
        end else if (kind < 11) begin
            if (f3 == 1) begin
                imm = imm % 32;
            end else if (f3 == 5) begin
                imm = (imm % 32) | (($urandom % 2 == 1) ? 'h400 : 0);
            end
            return enc_i(imm, rs1, f3, rd);
        end else if (kind < 13) begin
            return enc_lui($urandom, rd);
        end else if (kind == 13) begin
            return enc_r(($urandom % 128) | 1, rs2, rs1, f3, rd);
        end else if (kind == 14) begin
            // Shift immediate with a funct7 that is never valid
            return enc_i((imm & 'hfdf) | 'h020, rs1, (f3 % 2 == 1) ? 1 : 5, rd);
        end
        return {25'($urandom), 7'b1100011};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic issue(input logic [31:0] insn);
        exp_t e;
        @(posedge clk_i);
        insn_vld_i <= 1'b1;
        insn_i     <= insn;
        e           = model_execute(insn);
        // Edges are numbered by the negedge that follows them
        e.issue_cyc = neg_cnt + 1;
        exp_q.push_back(e);
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        insn_vld_i <= 1'b0;
        insn_i     <= $urandom;
    endtask

    // Retire comparator sampled away from the rising edge
    always @(negedge clk_i) begin
        exp_t e;
        neg_cnt = neg_cnt + 1;
        if (rst_ni && retire_vld_o !== 1'b0) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: retire seen with no instruction outstanding", $time);
                failure_cnt++;
            end else begin
                e = exp_q.pop_front();
                check_value("retire_cycle", neg_cnt, e.issue_cyc + LATENCY);
                check_value("retire_illegal_o", 32'(retire_illegal_o), 32'(e.illegal));
                check_value("retire_wen_o", 32'(retire_wen_o), 32'(e.wen));
                check_value("retire_rd_o", 32'(retire_rd_o), 32'(e.rd));
                if (!e.illegal) begin
                    check_value("retire_data_o", retire_data_o, e.data);
                end
            end
        end
    end

    initial begin
        int unsigned wait_cnt;
        void'($urandom(SEED));
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        rst_ni     = 1'b0;
        insn_vld_i = 1'b0;
        insn_i     = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        // Quiet period where nothing may retire
        repeat (6) idle_cycle();

        // Operands including a negative one
        issue(enc_i('hffb, 0, 0, 1));
        issue(enc_i('h003, 0, 0, 2));
        issue(enc_lui('h80000, 3));
        // Every R-type op
        issue(enc_r(0, 2, 1, 0, 4));
        issue(enc_r('h20, 2, 1, 0, 5));
        issue(enc_r(0, 2, 1, 1, 6));
        issue(enc_r(0, 2, 1, 2, 7));
        issue(enc_r(0, 2, 1, 3, 8));
        issue(enc_r(0, 2, 1, 4, 9));
        issue(enc_r(0, 2, 3, 5, 10));
        issue(enc_r('h20, 2, 3, 5, 11));
        issue(enc_r(0, 2, 1, 6, 12));
        issue(enc_r(0, 2, 1, 7, 13));
        // Every I-type op
        issue(enc_i('hfff, 1, 2, 14));
        issue(enc_i('h001, 1, 3, 15));
        issue(enc_i('h0f0, 1, 4, 16));
        issue(enc_i('h800, 2, 6, 17));
        issue(enc_i('h0ff, 1, 7, 18));
        issue(enc_i('h01f, 2, 1, 19));
        issue(enc_i('h004, 3, 5, 20));
        issue(enc_i('h404, 3, 5, 21));
        // x0 as destination and then read back
        issue(enc_i('h005, 1, 0, 0));
        issue(enc_lui('h12345, 0));
        issue(enc_r(0, 0, 0, 0, 22));
        // Dependencies at distance 1, 2 and 3
        issue(enc_i('h001, 0, 0, 23));
        issue(enc_i('h001, 23, 0, 23));
        issue(enc_i('h064, 0, 0, 24));
        issue(enc_i('h000, 0, 0, 0));
        issue(enc_r(0, 24, 23, 0, 25));
        issue(enc_i('h000, 0, 0, 0));
        issue(enc_i('h000, 0, 0, 0));
        issue(enc_r(0, 25, 25, 0, 26));
        // Illegal encodings must leave x4, x5 and x6 alone
        issue(enc_r('h01, 2, 3, 0, 4));
        issue({12'h000, 5'd1, 3'd0, 5'd5, 7'b1100011});
        issue(enc_i('h041, 1, 1, 6));
        issue(enc_r(0, 5, 4, 0, 27));
        issue(enc_r(0, 6, 0, 0, 28));

        for (int n = 0; n < RANDOM_COUNT; n++) begin
            if ($urandom % 4 == 0) begin
                idle_cycle();
            end
            issue(random_insn());
        end
        idle_cycle();

        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
            @(posedge clk_i);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR: timeout, %0d instructions never retired", exp_q.size());
            failure_cnt++;
        end
        // Catch any extra retire after the last expected one
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_i);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, failure_cnt);
        if (mismatch_cnt == 0 && failure_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
